// ==== sim.f ====
+incdir+.
uartPkg.sv
uartTxIf.sv
uartTx.sv
uartRx.sv
uartRegs.sv
uart.sv
uartTb.sv

// ==== uart.sv ====
`timescale 1ns/10ps
`include "uart_cfg.svh"

module uart (
	input logic CLK,
	input logic rst,
	input logic [1:0] ADDR,
	input logic RD,
	input logic WR,
	input logic [15:0] DIN,
	output logic [15:0] DOUT,
	output logic UART_INT,
	input logic RXD,
	output logic TXD
);

	// per direction clocks per bit from the register block
	logic [15:0] txDiv;
	logic [15:0] rxDiv;
	// received byte handed from the receiver to the holding register
	logic [`UART_DATA_BITS-1:0] rxData;
	logic rxValid;
	logic rxStopOk;

	// transmit handshake bundle
	uartTxIf txBus ();

	uartRegs u_regs (
		.CLK(CLK),
		.rst(rst),
		.ADDR(ADDR),
		.RD(RD),
		.WR(WR),
		.DIN(DIN),
		.DOUT(DOUT),
		.UART_INT(UART_INT),
		.tx(txBus.regs),
		.txDiv(txDiv),
		.rxDiv(rxDiv),
		.rxData(rxData),
		.rxValid(rxValid),
		.rxStopOk(rxStopOk)
	);

	uartTx u_tx (
		.CLK(CLK),
		.rst(rst),
		.tx(txBus.xmit),
		.txDiv(txDiv),
		.TXD(TXD)
	);

	uartRx u_rx (
		.CLK(CLK),
		.rst(rst),
		.RXD(RXD),
		.rxDiv(rxDiv),
		.rxData(rxData),
		.rxValid(rxValid),
		.rxStopOk(rxStopOk)
	);

endmodule

// ==== uartPkg.sv ====
package uartPkg;

	// status word as seen on the bus at address 0
	// the field order follows the UART_STAT_* bit positions, msb first
	typedef struct packed {
		// unused upper bits always read as zero
		logic [8:0] reserved;
		// a byte arrived while the previous one was still unread
		logic ovr;
		// transmit interrupt enable
		logic txie;
		// receive interrupt enable
		logic rxie;
		// stop bit of the held byte was high
		logic rxf;
		// transmitter is idle or has finished its last frame
		logic txc;
		// a transmission completed and the status has not been read since
		logic txi;
		// a received byte is waiting in the holding register
		logic rxi;
	} uartStatus_t;

	// one bus read word, taken either as the status layout or as a plain
	// sixteen bit value for the data byte and the dividers
	typedef union packed {
		uartStatus_t status;
		logic [15:0] raw;
	} uartWord_u;

endpackage

// ==== uartRegs.sv ====
`timescale 1ns/10ps
`include "uart_cfg.svh"

module uartRegs
	import uartPkg::*;
(
	input logic CLK,
	input logic rst,
	input logic [1:0] ADDR,
	input logic RD,
	input logic WR,
	input logic [15:0] DIN,
	output logic [15:0] DOUT,
	output logic UART_INT,
	uartTxIf.regs tx,
	output logic [15:0] txDiv,
	output logic [15:0] rxDiv,
	input logic [`UART_DATA_BITS-1:0] rxData,
	input logic rxValid,
	input logic rxStopOk
);

	// flags visible in the status word
	logic rxi;
	logic txi;
	logic txc;
	logic rxf;
	logic rxie;
	logic txie;
	logic ovr;
	// last received byte, held until the next one replaces it
	logic [`UART_DATA_BITS-1:0] holdByte;

	// decoded bus strobes
	logic statusRead;
	logic dataRead;
	logic statusWrite;
	logic dataWrite;
	logic txDivWrite;
	logic rxDivWrite;
	// a data write is taken only when the transmitter is free
	logic txAccept;
	// divider write value after the lower bound
	logic [15:0] divFloor;

	uartStatus_t statusWord;
	uartWord_u rdWord;

	assign statusRead = RD && (ADDR == `UART_ADDR_STATUS);
	assign dataRead = RD && (ADDR == `UART_ADDR_DATA);
	assign statusWrite = WR && (ADDR == `UART_ADDR_STATUS);
	assign dataWrite = WR && (ADDR == `UART_ADDR_DATA);
	assign txDivWrite = WR && (ADDR == `UART_ADDR_TXDIV);
	assign rxDivWrite = WR && (ADDR == `UART_ADDR_RXDIV);

	// txc stays low from an accepted write until txDone
	// which also covers the cycle where txStart is still pending
	assign txAccept = dataWrite && txc && !tx.txBusy;

	// the bit timers need at least two clocks per bit
	assign divFloor = (DIN < `UART_DIV_MIN) ? `UART_DIV_MIN : DIN;

	always_comb begin
		statusWord = '0;
		statusWord.rxi = rxi;
		statusWord.txi = txi;
		statusWord.txc = txc;
		statusWord.rxf = rxf;
		statusWord.rxie = rxie;
		statusWord.txie = txie;
		statusWord.ovr = ovr;
	end

	// read word mux, status goes in through its field layout
	// and everything else as a plain word
	always_comb begin
		rdWord.raw = '0;
		case (ADDR)
			`UART_ADDR_STATUS: rdWord.status = statusWord;
			`UART_ADDR_DATA: rdWord.raw = {8'h00, holdByte};
			`UART_ADDR_TXDIV: rdWord.raw = txDiv;
			`UART_ADDR_RXDIV: rdWord.raw = rxDiv;
			default: rdWord.raw = '0;
		endcase
	end

	// DOUT only changes on a read strobe and holds in between
	always_ff @(posedge CLK) begin
		if (RD) begin
			DOUT <= rdWord.raw;
		end
	end

	always_ff @(posedge CLK) begin
		if (txAccept) begin
			tx.txData <= DIN[`UART_DATA_BITS-1:0];
		end
		if (rxValid) begin
			holdByte <= rxData;
		end
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			txDiv <= `UART_DIV_RESET;
			rxDiv <= `UART_DIV_RESET;
			tx.txStart <= 1'b0;
			rxi <= 1'b0;
			txi <= 1'b0;
			txc <= 1'b1;
			rxf <= 1'b0;
			rxie <= 1'b0;
			txie <= 1'b0;
			ovr <= 1'b0;
			UART_INT <= 1'b0;
		end else begin
			if (txDivWrite) begin
				txDiv <= divFloor;
			end
			if (rxDivWrite) begin
				rxDiv <= divFloor;
			end
			if (statusWrite) begin
				rxie <= DIN[`UART_STAT_RXIE];
				txie <= DIN[`UART_STAT_TXIE];
			end

			// start pulses in the cycle after the accepted write
			tx.txStart <= txAccept;

			// completion wins over a clear in the same cycle
			if (tx.txDone) begin
				txc <= 1'b1;
			end else if (txAccept) begin
				txc <= 1'b0;
			end
			if (tx.txDone) begin
				txi <= 1'b1;
			end else if (statusRead) begin
				txi <= 1'b0;
			end

			// a new byte replaces the held one, overrun only if it was unread
			if (rxValid) begin
				rxi <= 1'b1;
				rxf <= rxStopOk;
			end else if (dataRead) begin
				rxi <= 1'b0;
				rxf <= 1'b0;
			end
			if (rxValid && rxi && !dataRead) begin
				ovr <= 1'b1;
			end else if (statusRead) begin
				ovr <= 1'b0;
			end

			// registered interrupt, one cycle behind the flags
			UART_INT <= (rxi && rxie) || (txi && txie);
		end
	end

endmodule

// ==== uartRx.sv ====
`timescale 1ns/10ps
`include "uart_cfg.svh"

module uartRx (
	input logic CLK,
	input logic rst,
	input logic RXD,
	input logic [15:0] rxDiv,
	output logic [`UART_DATA_BITS-1:0] rxData,
	output logic rxValid,
	output logic rxStopOk
);

	// receiver states
	localparam logic [1:0] IDLE = 2'd0;
	localparam logic [1:0] START = 2'd1;
	localparam logic [1:0] DATA = 2'd2;
	localparam logic [1:0] STOP = 2'd3;

	logic [1:0] state;
	// two flop synchronizer for the asynchronous line
	logic rxMeta;
	logic rxSync;
	// previous synchronized level for falling edge detection
	logic rxPrev;
	// divider captured at the start edge, used for the whole frame
	logic [15:0] divLatched;
	// cycles left until the next sample point
	logic [15:0] cycCnt;
	// number of data bits taken so far
	logic [2:0] bitCnt;
	// data bits arrive lsb first and shift in from the top
	logic [`UART_DATA_BITS-1:0] rxShift;

	always_ff @(posedge CLK) begin
		if (rst) begin
			rxMeta <= 1'b1;
			rxSync <= 1'b1;
			rxPrev <= 1'b1;
		end else begin
			rxMeta <= RXD;
			rxSync <= rxMeta;
			rxPrev <= rxSync;
		end
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			state <= IDLE;
			cycCnt <= '0;
			bitCnt <= '0;
			rxValid <= 1'b0;
		end else begin
			rxValid <= 1'b0;
			case (state)
				IDLE: begin
					// a high to low step on the line may be a start bit
					if (rxPrev && !rxSync) begin
						divLatched <= rxDiv;
						// land on the middle of the start bit
						cycCnt <= (rxDiv >> 1) - 16'd1;
						state <= START;
					end
				end
				START: begin
					if (cycCnt == 16'd0) begin
						if (rxSync) begin
							// line is back high, treat it as a glitch and rearm
							state <= IDLE;
						end else begin
							cycCnt <= divLatched - 16'd1;
							bitCnt <= '0;
							state <= DATA;
						end
					end else begin
						cycCnt <= cycCnt - 16'd1;
					end
				end
				DATA: begin
					if (cycCnt == 16'd0) begin
						rxShift <= {rxSync, rxShift[`UART_DATA_BITS-1:1]};
						cycCnt <= divLatched - 16'd1;
						if (bitCnt == 3'(`UART_DATA_BITS - 1)) begin
							state <= STOP;
						end else begin
							bitCnt <= bitCnt + 3'd1;
						end
					end else begin
						cycCnt <= cycCnt - 16'd1;
					end
				end
				STOP: begin
					if (cycCnt == 16'd0) begin
						// hand over the byte with its stop level
						// a low stop bit is reported, not dropped
						rxData <= rxShift;
						rxStopOk <= rxSync;
						rxValid <= 1'b1;
						state <= IDLE;
					end else begin
						cycCnt <= cycCnt - 16'd1;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

endmodule

// ==== uartTb.sv ====
`timescale 1ns/10ps
`include "uart_cfg.svh"

module uartTb
	import uartPkg::*;
();

	// frames sent on both lines over the run and the slowest divider used
	localparam int FRAMES = 25;
	localparam int MAXDIV = 20;
	localparam int LIMIT_NS = FRAMES * 10 * MAXDIV * 10 * 2 + 20000;

	logic CLK = 1'b0;
	logic rst;
	logic [1:0] ADDR;
	logic RD;
	logic WR;
	logic [15:0] DIN;
	logic [15:0] DOUT;
	logic UART_INT;
	logic RXD;
	logic TXD;

	// flag state the DUT should hold as the bus and the lines act on it
	uartStatus_t mdl;
	// divider the TXD monitor decodes with
	int txDivM;
	// frames seen on TXD with the first line level in bit 0
	logic [9:0] txQ[$];
	int rxCount = 0;
	int txCount = 0;
	int rxWant = 0;
	int txWant = 0;
	int checks = 0;
	int errors = 0;
	int testErr = 0;

	uart u_dut (.*);

	always #5 CLK = ~CLK;

	// completion pulses are counted mid cycle where they are stable
	always @(negedge CLK) begin
		if (u_dut.rxValid) rxCount++;
		if (u_dut.txBus.txDone) txCount++;
	end

	initial begin
		#(LIMIT_NS);
		$display("run timed out after %0d ns with the DUT still not done", LIMIT_NS);
		$display("Checks failed");
		$finish;
	end

	// serial peer on TXD that samples each bit near its middle
	initial begin : txMonitor
		int d;
		logic [9:0] bits;
		forever begin
			@(negedge TXD);
			d = txDivM;
			repeat (d / 2) @(negedge CLK);
			for (int i = 0; i < 10; i++) begin
				bits[i] = TXD;
				if (i < 9) repeat (d) @(negedge CLK);
			end
			txQ.push_back(bits);
		end
	end

	// status word placed by the bit table and not by the struct layout
	function automatic uartWord_u expStatus(input uartStatus_t s);
		uartWord_u w;
		w.raw = '0;
		w.raw[`UART_STAT_RXI] = s.rxi;
		w.raw[`UART_STAT_TXI] = s.txi;
		w.raw[`UART_STAT_TXC] = s.txc;
		w.raw[`UART_STAT_RXF] = s.rxf;
		w.raw[`UART_STAT_RXIE] = s.rxie;
		w.raw[`UART_STAT_TXIE] = s.txie;
		w.raw[`UART_STAT_OVR] = s.ovr;
		return w;
	endfunction

	// 8N1 line levels with a low start bit, data lsb first and a high stop bit
	function automatic logic [9:0] expFrame(input logic [7:0] b);
		return {1'b1, b, 1'b0};
	endfunction

	function automatic logic expIrq(input uartStatus_t s);
		return (s.rxi && s.rxie) || (s.txi && s.txie);
	endfunction

	task automatic checkWord(input string name, input uartWord_u got, input uartWord_u exp);
		checks++;
		if (got.raw !== exp.raw) begin
			errors++;
			$display("Fail %0t %s got %h expected %h", $time, name, got.raw, exp.raw);
		end
	endtask

	task automatic checkByte(input string name, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %0t %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// bus tasks start and end 1 ns after a rising edge
	task automatic busWrite(input logic [1:0] a, input logic [15:0] d);
		ADDR = a;
		DIN = d;
		WR = 1'b1;
		@(posedge CLK);
		#1;
		WR = 1'b0;
	endtask

	task automatic busRead(input logic [1:0] a, output logic [15:0] d);
		ADDR = a;
		RD = 1'b1;
		@(posedge CLK);
		#1;
		RD = 1'b0;
		d = DOUT;
	endtask

	// reading status clears TXI and OVR
	task automatic readStatus();
		uartWord_u w;
		busRead(`UART_ADDR_STATUS, w.raw);
		checkWord("DOUT status", w, expStatus(mdl));
		mdl.txi = 1'b0;
		mdl.ovr = 1'b0;
	endtask

	// reading data clears RXI and RXF
	task automatic readData(input logic [7:0] exp);
		logic [15:0] d;
		busRead(`UART_ADDR_DATA, d);
		checkByte("DOUT data", d[7:0], exp);
		checkByte("DOUT data upper", d[15:8], 8'h00);
		mdl.rxi = 1'b0;
		mdl.rxf = 1'b0;
	endtask

	task automatic readDiv(input logic [1:0] a, input logic [15:0] exp);
		uartWord_u w;
		uartWord_u e;
		busRead(a, w.raw);
		e.raw = exp;
		checkWord("DOUT divider", w, e);
	endtask

	task automatic setEnables(input logic rxie, input logic txie);
		busWrite(`UART_ADDR_STATUS, {10'b0, txie, rxie, 4'b0});
		mdl.rxie = rxie;
		mdl.txie = txie;
	endtask

	// waits a bounded number of cycles for the next completion pulse of one direction
	task automatic waitDone(input bit isTx);
		int n;
		n = 0;
		if (isTx) txWant++;
		else rxWant++;
		while ((isTx ? txCount < txWant : rxCount < rxWant) && n < 30 * MAXDIV) begin
			@(posedge CLK);
			#1;
			n++;
		end
		if (isTx ? txCount < txWant : rxCount < rxWant) begin
			errors++;
			$display("no %s completion from the DUT by %0t", isTx ? "transmit" : "receive", $time);
		end
	endtask

	// drives one frame on RXD and marks an overrun if the held byte was still unread
	task automatic sendFrame(input logic [7:0] b, input int d, input logic stopBit);
		logic [9:0] f;
		f = {stopBit, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			RXD = f[i];
			repeat (d) @(posedge CLK);
			#1;
		end
		RXD = 1'b1;
		waitDone(1'b0);
		mdl.ovr = mdl.ovr | mdl.rxi;
		mdl.rxi = 1'b1;
		mdl.rxf = stopBit;
	endtask

	task automatic finishTx(input logic [7:0] b);
		logic [9:0] f;
		logic [9:0] e;
		waitDone(1'b1);
		mdl.txc = 1'b1;
		mdl.txi = 1'b1;
		e = expFrame(b);
		if (txQ.size() == 0) begin
			errors++;
			$display("no frame was decoded from TXD by %0t", $time);
		end else begin
			f = txQ.pop_front();
			checkByte("TXD data", f[8:1], e[8:1]);
			checkByte("TXD stop and start", {6'b0, f[9], f[0]}, {6'b0, e[9], e[0]});
		end
	endtask

	// TXC must read low while the frame is on the line
	task automatic transmit(input logic [7:0] b);
		busWrite(`UART_ADDR_DATA, {8'h00, b});
		mdl.txc = 1'b0;
		readStatus();
		finishTx(b);
	endtask

	// the registered interrupt follows the flags one edge later
	task automatic checkIrq();
		@(posedge CLK);
		#1;
		checkByte("UART_INT", {7'b0, UART_INT}, {7'b0, expIrq(mdl)});
	endtask

	task automatic endTest(input string name);
		$display("test %s done with %0d errors", name, errors - testErr);
		testErr = errors;
	endtask

	initial begin
		logic [7:0] b;
		int d;
		void'($urandom(32'ha75b240b));
		rst = 1'b1;
		ADDR = '0;
		RD = 1'b0;
		WR = 1'b0;
		DIN = '0;
		RXD = 1'b1;
		txDivM = `UART_DIV_RESET;
		mdl = '0;
		mdl.txc = 1'b1;
		repeat (4) @(posedge CLK);
		#1;
		rst = 1'b0;

		readStatus();
		readDiv(`UART_ADDR_TXDIV, `UART_DIV_RESET);
		readDiv(`UART_ADDR_RXDIV, `UART_DIV_RESET);
		busWrite(`UART_ADDR_TXDIV, 16'd1);
		busWrite(`UART_ADDR_RXDIV, 16'd0);
		readDiv(`UART_ADDR_TXDIV, `UART_DIV_MIN);
		readDiv(`UART_ADDR_RXDIV, `UART_DIV_MIN);
		endTest("reset and divider floor");

		busWrite(`UART_ADDR_TXDIV, 16'd4);
		txDivM = 4;
		transmit(8'hA5);
		readStatus();
		readStatus();
		endTest("transmit");

		// random bytes at random dividers from 2 to 20
		for (int i = 0; i < 16; i++) begin
			b = 8'($urandom);
			d = 2 + int'($urandom % 19);
			busWrite(`UART_ADDR_RXDIV, 16'(d));
			sendFrame(b, d, 1'b1);
			readStatus();
			readData(b);
			readStatus();
		end
		endTest("receive");

		busWrite(`UART_ADDR_RXDIV, 16'd8);
		sendFrame(8'h3C, 8, 1'b0);
		readStatus();
		readData(8'h3C);
		sendFrame(8'h81, 8, 1'b1);
		sendFrame(8'h7E, 8, 1'b1);
		readStatus();
		readData(8'h7E);
		endTest("bad stop and overrun");

		setEnables(1'b1, 1'b0);
		checkIrq();
		sendFrame(8'h42, 8, 1'b1);
		checkIrq();
		readData(8'h42);
		checkIrq();
		setEnables(1'b0, 1'b1);
		transmit(8'h96);
		checkIrq();
		readStatus();
		checkIrq();
		setEnables(1'b0, 1'b0);
		sendFrame(8'h24, 8, 1'b1);
		checkIrq();
		transmit(8'h18);
		checkIrq();
		readStatus();
		readData(8'h24);
		endTest("interrupt");

		// the second write lands while the first frame is still pending
		busWrite(`UART_ADDR_DATA, 16'h00C3);
		mdl.txc = 1'b0;
		busWrite(`UART_ADDR_DATA, 16'h003C);
		finishTx(8'hC3);
		// a second frame would show up on TXD within one more frame time
		repeat (12 * txDivM) @(posedge CLK);
		#1;
		checks++;
		if (txQ.size() != 0 || txCount != txWant) begin
			errors++;
			$display("a data write while the transmitter was busy sent a second frame");
		end
		readStatus();
		endTest("write while busy");

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// ==== uartTx.sv ====
`timescale 1ns/10ps
`include "uart_cfg.svh"

module uartTx (
	input logic CLK,
	input logic rst,
	uartTxIf.xmit tx,
	input logic [15:0] txDiv,
	output logic TXD
);

	// frame shifter, bit 0 is the level currently on the line
	logic [`UART_FRAME_BITS-1:0] frame;
	// divider captured at txStart so a later write waits for the next frame
	logic [15:0] divLatched;
	// cycles left in the current bit, counting down to zero
	logic [15:0] cycCnt;
	// index of the bit being sent, 0 is the start bit
	logic [3:0] bitCnt;
	// frame in progress, stays high through the final stop bit cycle
	logic active;
	logic busyReg;
	logic doneReg;

	assign TXD = frame[0];
	assign tx.txBusy = busyReg;
	assign tx.txDone = doneReg;

	always_ff @(posedge CLK) begin
		if (rst) begin
			// an all-ones shifter keeps the line idle high
			frame <= '1;
			cycCnt <= '0;
			bitCnt <= '0;
			active <= 1'b0;
			busyReg <= 1'b0;
			doneReg <= 1'b0;
		end else begin
			// done is only ever a single cycle pulse
			doneReg <= 1'b0;
			if (tx.txStart) begin
				// start bit low, data lsb first, then the high stop bit
				frame <= {1'b1, tx.txData, 1'b0};
				divLatched <= txDiv;
				cycCnt <= txDiv - 16'd1;
				bitCnt <= '0;
				active <= 1'b1;
				busyReg <= 1'b1;
			end else if (active) begin
				if (cycCnt == 16'd0) begin
					if (bitCnt == 4'(`UART_FRAME_BITS - 1)) begin
						// stop bit finished, the line rests on the stop level
						active <= 1'b0;
					end else begin
						// shift in ones so the line stays high after the frame
						frame <= {1'b1, frame[`UART_FRAME_BITS-1:1]};
						cycCnt <= divLatched - 16'd1;
						bitCnt <= bitCnt + 4'd1;
					end
				end else begin
					cycCnt <= cycCnt - 16'd1;
					// the next cycle is the last one of the stop bit
					// so done pulses there and busy drops on the same edge
					if (bitCnt == 4'(`UART_FRAME_BITS - 1) && cycCnt == 16'd1) begin
						doneReg <= 1'b1;
						busyReg <= 1'b0;
					end
				end
			end
		end
	end

endmodule

// ==== uartTxIf.sv ====
`timescale 1ns/10ps
`include "uart_cfg.svh"

// transmit handshake between the register block and the transmitter
interface uartTxIf;

	// byte to send, valid while txStart is high
	logic [`UART_DATA_BITS-1:0] txData;
	// one cycle request, only raised while txBusy is low
	logic txStart;
	// high from the edge after txStart until the last stop bit cycle
	logic txBusy;
	// one cycle pulse in the last cycle of the stop bit
	logic txDone;

	// register block side issues the byte and watches for completion
	modport regs (
		output txData,
		output txStart,
		input txBusy,
		input txDone
	);

	// transmitter side takes the byte and reports its progress
	modport xmit (
		input txData,
		input txStart,
		output txBusy,
		output txDone
	);

endinterface

// ==== uart_cfg.svh ====
`ifndef UART_CFG_SVH
`define UART_CFG_SVH

// register addresses on the two-bit bus
`define UART_ADDR_STATUS 2'd0
`define UART_ADDR_DATA 2'd1
`define UART_ADDR_TXDIV 2'd2
`define UART_ADDR_RXDIV 2'd3

// bit positions inside the status word
`define UART_STAT_RXI 0
`define UART_STAT_TXI 1
`define UART_STAT_TXC 2
`define UART_STAT_RXF 3
`define UART_STAT_RXIE 4
`define UART_STAT_TXIE 5
`define UART_STAT_OVR 6

// clocks per bit after reset, and the smallest divider the timers can handle
`define UART_DIV_RESET 16'd104
`define UART_DIV_MIN 16'd2

// 8N1 frame: start bit, eight data bits and one stop bit
`define UART_DATA_BITS 8
`define UART_FRAME_BITS 10

`endif
